// File: source/soc_pkg.sv
// shared request/response structs, size codes and i/o map for the data-memory subsystem

package soc_pkg;

  // risc-v funct3 size codes for loads and stores
  localparam logic [2:0] SIZE_B  = 3'd0;  // signed byte
  localparam logic [2:0] SIZE_H  = 3'd1;  // signed halfword
  localparam logic [2:0] SIZE_W  = 3'd2;  // word
  localparam logic [2:0] SIZE_BU = 3'd4;  // unsigned byte
  localparam logic [2:0] SIZE_HU = 3'd5;  // unsigned halfword

  // address bit 28 set selects the i/o block, clear selects ram
  localparam int IO_SEL_BIT = 28;

  // word offsets inside the i/o block, only the low bit is decoded
  localparam int unsigned GPIO_OFFSET    = 0;  // read/write
  localparam int unsigned COUNTER_OFFSET = 1;  // read only

  // cpu-side request, one-cycle strobe
  typedef struct packed {
    logic        valid;   // request strobe
    logic        store;   // 1 = store, 0 = load
    logic [2:0]  funct3;  // size code
    logic [31:0] addr;    // byte address
    logic [31:0] wdata;   // store data, right-justified
  } mem_req_t;

  // word-level request after alignment
  typedef struct packed {
    logic        valid;   // request present this cycle
    logic        fault;   // misaligned or unknown size
    logic [3:0]  wmask;   // byte-write mask, zero for loads
    logic [29:0] waddr;   // word address
    logic [31:0] wdata;   // data moved onto its byte lanes
  } lane_req_t;

  // response, one cycle after the request edge
  typedef struct packed {
    logic        ready;   // request done
    logic        fault;   // request refused
    logic [31:0] rdata;   // load data, zero for stores
  } mem_resp_t;

endpackage

// File: source/store_align.sv
// combinational alignment check and byte-lane placement of a cpu load/store request
`timescale 1ns/10ps

module store_align (
  input  soc_pkg::mem_req_t  req,   // request from the cpu side
  output soc_pkg::lane_req_t lane   // word address, mask and lane data
);

  logic [1:0]  offset;      // byte offset inside the word
  logic        size_ok;     // funct3 is one of the five known codes
  logic        misaligned;  // access crosses its natural boundary
  logic [3:0]  base_mask;   // mask for offset 0, shifted below
  logic [31:0] lane_data;   // store data copied onto every lane it may hit

  assign offset = req.addr[1:0];

  always_comb begin
    size_ok    = 1'b1;
    misaligned = 1'b0;
    base_mask  = 4'b0000;
    lane_data  = req.wdata;
    case (req.funct3)
      soc_pkg::SIZE_B, soc_pkg::SIZE_BU: begin
        base_mask = 4'b0001;                 // any offset is fine
        lane_data = {4{req.wdata[7:0]}};     // byte on all four lanes
      end
      soc_pkg::SIZE_H, soc_pkg::SIZE_HU: begin
        misaligned = offset[0];              // odd address
        base_mask  = 4'b0011;
        lane_data  = {2{req.wdata[15:0]}};   // half on both half lanes
      end
      soc_pkg::SIZE_W: begin
        misaligned = |offset;                // must be a multiple of 4
        base_mask  = 4'b1111;
      end
      default: begin
        size_ok = 1'b0;                      // reserved code
      end
    endcase
  end

  assign lane.valid = req.valid;
  assign lane.fault = req.valid && (!size_ok || misaligned);
  assign lane.wmask = req.store ? (base_mask << offset) : 4'b0000;  // loads write nothing
  assign lane.waddr = req.addr[31:2];
  assign lane.wdata = lane_data;

endmodule

// File: source/byte_lane_ram.sv
// four-lane byte-writable block ram with registered one-cycle read
`timescale 1ns/10ps

module byte_lane_ram #(
  parameter int RAM_ADDR_WIDTH = 10  // word-address bits
) (
  input  logic                      clk,
  input  logic [RAM_ADDR_WIDTH-1:0] addr,   // word address
  input  logic [31:0]               wdata,  // lane-shifted store data
  input  logic [3:0]                wmask,  // one bit per byte lane
  output logic [31:0]               rdata   // word read at the previous edge
);

  localparam int DEPTH = 1 << RAM_ADDR_WIDTH;

  logic primed = 1'b0;  // set after the first edge

  always_ff @(posedge clk) begin
    primed <= 1'b1;
  end

  // one byte-wide array per lane so each maps onto its own ram column
  for (genvar i = 0; i < 4; i++) begin : g_lane
    logic [7:0] mem [DEPTH];  // no init, contents undefined until written
    logic [7:0] q;            // registered lane read

    always_ff @(posedge clk) begin
      if (wmask[i]) begin
        mem[addr] <= wdata[8*i +: 8];
      end
      q <= mem[addr];  // read-before-write, old byte on a collision
    end

    assign rdata[8*i +: 8] = q;
  end

  // a floating mask would corrupt lanes silently
  a_wmask_known: assert property (
    @(posedge clk) primed |-> !$isunknown(wmask)
  ) else $error("byte_lane_ram: wmask unknown 0x%h", wmask);

endmodule

// File: source/io_regs.sv
// small i/o register block with a gpio output register and a free-running cycle counter
`timescale 1ns/10ps

module io_regs (
  input  logic        clk,
  input  logic        rst,
  input  logic        word_sel,  // low bit of the i/o word offset
  input  logic [31:0] wdata,     // lane-shifted store data
  input  logic [3:0]  wmask,     // byte-write mask, zero unless an i/o store
  output logic [31:0] rdata,     // registered read of the selected word
  output logic [31:0] gpio       // gpio output pins
);

  logic [31:0] gpio_q;   // gpio output register
  logic [31:0] counter;  // cycles since reset
  logic        gpio_sel; // request addresses the gpio word

  assign gpio_sel = (word_sel == soc_pkg::GPIO_OFFSET[0]);

  // gpio written byte by byte, counter word ignores writes
  always_ff @(posedge clk) begin
    if (rst) begin
      gpio_q <= 32'd0;
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (gpio_sel && wmask[i]) begin
          gpio_q[8*i +: 8] <= wdata[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      counter <= 32'd0;
    end else begin
      counter <= counter + 32'd1;  // wraps after 2^32 cycles
    end
  end

  // value as it stood at the request edge, same timing as the ram
  always_ff @(posedge clk) begin
    if (word_sel == soc_pkg::COUNTER_OFFSET[0]) begin
      rdata <= counter;
    end else begin
      rdata <= gpio_q;  // old gpio on a same-edge write
    end
  end

  assign gpio = gpio_q;

endmodule

// File: source/mem_decoder.sv
// address decode between ram and i/o, pending-target tracking and response pulse generation
`timescale 1ns/10ps

module mem_decoder (
  input  logic               clk,
  input  logic               rst,
  input  soc_pkg::lane_req_t lane,       // aligned request
  output logic [3:0]         ram_wmask,  // byte mask to the ram
  output logic [3:0]         io_wmask,   // byte mask to the i/o block
  input  logic [31:0]        ram_rdata,  // registered ram word
  input  logic [31:0]        io_rdata,   // registered i/o word
  output logic [31:0]        word,       // word of the target answering now
  output logic               ready,      // request accepted last edge
  output logic               fault       // request refused last edge
);

  // i/o select bit as seen in the word address
  localparam int IO_WORD_BIT = soc_pkg::IO_SEL_BIT - 2;

  logic is_io;     // current request targets the i/o block
  logic wr_ok;     // request may touch memory
  logic io_q;      // target of the request being answered
  logic ready_q;
  logic fault_q;

  assign is_io = lane.waddr[IO_WORD_BIT];
  assign wr_ok = lane.valid && !lane.fault;

  // loads already carry a zero mask, faults and idle cycles zeroed here
  assign ram_wmask = (wr_ok && !is_io) ? lane.wmask : 4'b0000;
  assign io_wmask  = (wr_ok && is_io)  ? lane.wmask : 4'b0000;

  // one stage, lines up with the read register in ram and i/o
  always_ff @(posedge clk) begin
    if (rst) begin
      io_q    <= 1'b0;
      ready_q <= 1'b0;
      fault_q <= 1'b0;
    end else begin
      io_q    <= is_io;
      ready_q <= wr_ok;
      fault_q <= lane.valid && lane.fault;
    end
  end

  assign word  = io_q ? io_rdata : ram_rdata;  // pick by the registered target
  assign ready = ready_q;
  assign fault = fault_q;

  // the two response pulses are exclusive
  a_no_double: assert property (
    @(posedge clk) disable iff (rst) !(ready && fault)
  ) else $error("mem_decoder: ready and fault high together");

endmodule

// File: source/load_align.sv
// load data shifter that moves the addressed bytes down and sign- or zero-extends them
`timescale 1ns/10ps

module load_align (
  input  logic        clk,
  input  logic        rst,
  input  logic [1:0]  lane_offset,  // byte offset of the request
  input  logic [2:0]  funct3,       // size code of the request
  input  logic        store,        // request is a store
  input  logic [31:0] word,         // word returned by the target
  output logic [31:0] rdata         // aligned load data
);

  logic [1:0]  offset_q;  // offset of the access being answered
  logic [2:0]  funct3_q;  // its size code
  logic        store_q;   // its store flag
  logic [31:0] shifted;   // addressed bytes moved to bit 0

  // captured at the request edge, used while the word comes back
  always_ff @(posedge clk) begin
    if (rst) begin
      offset_q <= 2'd0;
      funct3_q <= soc_pkg::SIZE_W;
      store_q  <= 1'b0;
    end else begin
      offset_q <= lane_offset;
      funct3_q <= funct3;
      store_q  <= store;
    end
  end

  assign shifted = word >> {offset_q, 3'b000};  // offset in bytes to bits

  always_comb begin
    if (store_q) begin
      rdata = 32'd0;  // stores return no data
    end else begin
      case (funct3_q)
        soc_pkg::SIZE_B:  rdata = {{24{shifted[7]}}, shifted[7:0]};
        soc_pkg::SIZE_BU: rdata = {24'd0, shifted[7:0]};
        soc_pkg::SIZE_H:  rdata = {{16{shifted[15]}}, shifted[15:0]};
        soc_pkg::SIZE_HU: rdata = {16'd0, shifted[15:0]};
        default:          rdata = shifted;  // word, offset is 0 here
      endcase
    end
  end

endmodule

// File: source/mem_subsystem.sv
// top level of the data-memory subsystem, joining alignment, decode, ram, i/o and load path
`timescale 1ns/10ps

module mem_subsystem #(
  parameter int RAM_ADDR_WIDTH = 10  // ram depth is 2^RAM_ADDR_WIDTH words
) (
  input  logic               clk,
  input  logic               rst,
  input  soc_pkg::mem_req_t  req,   // load/store strobe from the cpu
  output soc_pkg::mem_resp_t resp,  // ready/fault pulse with load data
  output logic [31:0]        gpio   // gpio output register
);

  soc_pkg::lane_req_t lane;       // aligned request
  logic [3:0]         ram_wmask;
  logic [3:0]         io_wmask;
  logic [31:0]        ram_rdata;
  logic [31:0]        io_rdata;
  logic [31:0]        word;       // word of the answering target
  logic               ready;
  logic               fault;
  logic [31:0]        rdata;      // aligned load data

  store_align u_store_align (
    .req  (req),
    .lane (lane)
  );

  mem_decoder u_mem_decoder (
    .clk       (clk),
    .rst       (rst),
    .lane      (lane),
    .ram_wmask (ram_wmask),
    .io_wmask  (io_wmask),
    .ram_rdata (ram_rdata),
    .io_rdata  (io_rdata),
    .word      (word),
    .ready     (ready),
    .fault     (fault)
  );

  // upper word-address bits ignored, ram aliases across its region
  byte_lane_ram #(
    .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
  ) u_ram (
    .clk   (clk),
    .addr  (lane.waddr[RAM_ADDR_WIDTH-1:0]),
    .wdata (lane.wdata),
    .wmask (ram_wmask),
    .rdata (ram_rdata)
  );

  io_regs u_io_regs (
    .clk      (clk),
    .rst      (rst),
    .word_sel (lane.waddr[0]),
    .wdata    (lane.wdata),
    .wmask    (io_wmask),
    .rdata    (io_rdata),
    .gpio     (gpio)
  );

  load_align u_load_align (
    .clk         (clk),
    .rst         (rst),
    .lane_offset (req.addr[1:0]),
    .funct3      (req.funct3),
    .store       (req.store),
    .word        (word),
    .rdata       (rdata)
  );

  assign resp = '{ready: ready, fault: fault, rdata: rdata};

endmodule

// File: bench/mem_subsystem_tb.sv
// self-checking testbench for mem_subsystem, run from flist.f with the top module mem_subsystem_tb
`timescale 1ns/10ps

module mem_subsystem_tb;

  localparam int PERIOD        = 4;   // ns
  localparam int RST_CYCLES    = 8;
  localparam int QUIET_CYCLES  = 3;   // idle cycles checked after reset
  localparam int MARGIN_CYCLES = 20;  // slack for the watchdog
  localparam int RAM_AW        = 10;

  localparam logic [1:0] CHK_NONE  = 2'd0;  // pulse only, data unknown
  localparam logic [1:0] CHK_DATA  = 2'd1;  // compare rdata
  localparam logic [1:0] CHK_DELTA = 2'd2;  // counter read, compare step

  localparam logic [31:0] GPIO_ADDR = 32'h1000_0000;  // bit 28 selects i/o
  localparam logic [31:0] CNT_ADDR  = 32'h1000_0004;

  // one row of the stimulus table with its expected response
  typedef struct packed {
    logic [3:0]        grp;        // test the row belongs to
    logic [1:0]        chk;        // how rdata is checked
    logic              exp_fault;  // fault expected instead of ready
    logic [31:0]       exp_gpio;   // gpio port in the response cycle
    logic [31:0]       exp_data;   // expected rdata
    soc_pkg::mem_req_t req;        // request driven on the bus
  } entry_t;

  logic               clk = 1'b0;
  logic               rst;
  soc_pkg::mem_req_t  req;
  soc_pkg::mem_resp_t resp;
  logic [31:0]        gpio;

  entry_t      tbl[$];              // stimulus table
  logic [31:0] ram_model [1 << RAM_AW];
  logic [31:0] gpio_model;
  logic [15:0] lfsr;
  logic        table_built = 1'b0;
  logic [31:0] last_cnt;            // previous counter read
  int          last_idx;            // its table row
  logic        cnt_seen = 1'b0;
  int          checks [7];
  int          errs [7];
  int          total_checks;
  int          total_errors;
  string       grp_name [7] = '{"reset_idle", "word", "subword", "fault", "random", "io",
                                "drain"};

  mem_subsystem #(
    .RAM_ADDR_WIDTH (RAM_AW)
  ) uut (
    .clk  (clk),
    .rst  (rst),
    .req  (req),
    .resp (resp),
    .gpio (gpio)
  );

  always #(PERIOD / 2) clk = ~clk;

  // 16-bit galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = 32'd0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_step(lfsr);   // one step per bit
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  // store data lands on the addressed bytes only
  function automatic logic [31:0] merge_store(input logic [31:0] old, input logic [2:0] f3,
                                              input logic [1:0] off, input logic [31:0] wd);
    logic [31:0] w;
    w = old;
    case (f3)
      soc_pkg::SIZE_B, soc_pkg::SIZE_BU: w[{off, 3'b000} +: 8] = wd[7:0];
      soc_pkg::SIZE_H, soc_pkg::SIZE_HU: w[{off[1], 4'b0000} +: 16] = wd[15:0];
      default: w = wd;
    endcase
    return w;
  endfunction

  function automatic logic [31:0] extend_load(input logic [31:0] word, input logic [2:0] f3,
                                              input logic [1:0] off);
    logic [7:0]  b;
    logic [15:0] h;
    b = word[{off, 3'b000} +: 8];
    h = word[{off[1], 4'b0000} +: 16];
    case (f3)
      soc_pkg::SIZE_B:  return 32'($signed(b));
      soc_pkg::SIZE_BU: return 32'(b);
      soc_pkg::SIZE_H:  return 32'($signed(h));
      soc_pkg::SIZE_HU: return 32'(h);
      default:          return word;
    endcase
  endfunction

  // append a row and update the models with its effect
  task automatic add_req(input logic st, input logic [2:0] f3, input logic [31:0] addr,
                         input logic [31:0] wd, input logic [3:0] grp);
    entry_t     e;
    logic       bad;
    logic [9:0] idx;
    idx = addr[11:2];  // ram aliases modulo its size
    bad = !(f3 inside {soc_pkg::SIZE_B, soc_pkg::SIZE_H, soc_pkg::SIZE_W,
                       soc_pkg::SIZE_BU, soc_pkg::SIZE_HU})
          || ((f3 == soc_pkg::SIZE_H || f3 == soc_pkg::SIZE_HU) && addr[0])
          || (f3 == soc_pkg::SIZE_W && addr[1:0] != 2'b00);
    e.req       = '{valid: 1'b1, store: st, funct3: f3, addr: addr, wdata: wd};
    e.grp       = grp;
    e.exp_fault = bad;
    e.exp_data  = 32'd0;  // stores answer with zero
    e.chk       = bad ? CHK_NONE : CHK_DATA;
    if (!bad) begin
      if (addr[soc_pkg::IO_SEL_BIT]) begin
        if (st && addr[2] == soc_pkg::GPIO_OFFSET[0]) begin
          gpio_model = merge_store(gpio_model, f3, addr[1:0], wd);
        end else if (!st && addr[2] == soc_pkg::COUNTER_OFFSET[0]) begin
          e.chk = CHK_DELTA;  // absolute count unknown
        end else if (!st) begin
          e.exp_data = extend_load(gpio_model, f3, addr[1:0]);
        end
      end else if (st) begin
        ram_model[idx] = merge_store(ram_model[idx], f3, addr[1:0], wd);
      end else begin
        e.exp_data = extend_load(ram_model[idx], f3, addr[1:0]);
      end
    end
    e.exp_gpio = gpio_model;  // gpio updates at the request edge
    tbl.push_back(e);
  endtask

  task automatic build_table();
    logic [31:0] d;
    logic [31:0] a;
    logic [9:0]  rnd_idx [32];
    gpio_model = 32'd0;
    lfsr       = 16'd18656;
    // word store then load, plus an aliased address
    add_req(1'b1, soc_pkg::SIZE_W, 32'h0000_0100, 32'hDEAD_BEEF, 4'd1);
    add_req(1'b0, soc_pkg::SIZE_W, 32'h0000_0100, 32'h0, 4'd1);
    add_req(1'b1, soc_pkg::SIZE_W, 32'h0000_0204, 32'h1234_5678, 4'd1);
    add_req(1'b0, soc_pkg::SIZE_W, 32'h0000_0204, 32'h0, 4'd1);
    add_req(1'b0, soc_pkg::SIZE_W, 32'h0000_1100, 32'h0, 4'd1);  // same ram word
    // sub-word stores merge into one word
    add_req(1'b1, soc_pkg::SIZE_B, 32'h0000_0300, 32'h0000_0081, 4'd2);
    add_req(1'b1, soc_pkg::SIZE_BU, 32'h0000_0301, 32'hFFFF_FF7F, 4'd2);  // upper bits dropped
    add_req(1'b1, soc_pkg::SIZE_H, 32'h0000_0302, 32'h0000_C3A5, 4'd2);
    add_req(1'b0, soc_pkg::SIZE_W, 32'h0000_0300, 32'h0, 4'd2);
    for (int off = 0; off < 4; off++) begin
      add_req(1'b0, soc_pkg::SIZE_B, 32'h0000_0300 + 32'(off), 32'h0, 4'd2);
      add_req(1'b0, soc_pkg::SIZE_BU, 32'h0000_0300 + 32'(off), 32'h0, 4'd2);
    end
    for (int off = 0; off < 4; off += 2) begin
      add_req(1'b0, soc_pkg::SIZE_H, 32'h0000_0300 + 32'(off), 32'h0, 4'd2);
      add_req(1'b0, soc_pkg::SIZE_HU, 32'h0000_0300 + 32'(off), 32'h0, 4'd2);
    end
    add_req(1'b1, soc_pkg::SIZE_HU, 32'h0000_0300, 32'h1234_8001, 4'd2);
    add_req(1'b1, soc_pkg::SIZE_B, 32'h0000_0303, 32'hFFFF_FF12, 4'd2);
    add_req(1'b0, soc_pkg::SIZE_W, 32'h0000_0300, 32'h0, 4'd2);
    // misaligned and unknown sizes, memory must stay intact
    add_req(1'b1, soc_pkg::SIZE_W, 32'h0000_0101, 32'h1111_1111, 4'd3);
    add_req(1'b1, soc_pkg::SIZE_W, 32'h0000_0102, 32'h2222_2222, 4'd3);
    add_req(1'b1, soc_pkg::SIZE_H, 32'h0000_0101, 32'h0000_3333, 4'd3);
    add_req(1'b1, soc_pkg::SIZE_HU, 32'h0000_0103, 32'h0000_4444, 4'd3);
    add_req(1'b0, soc_pkg::SIZE_W, 32'h0000_0103, 32'h0, 4'd3);
    add_req(1'b0, soc_pkg::SIZE_H, 32'h0000_0101, 32'h0, 4'd3);
    add_req(1'b1, 3'd3, 32'h0000_0100, 32'h5555_5555, 4'd3);  // reserved code
    add_req(1'b0, 3'd6, 32'h0000_0100, 32'h0, 4'd3);
    add_req(1'b0, 3'd7, 32'h0000_0100, 32'h0, 4'd3);
    add_req(1'b1, soc_pkg::SIZE_W, GPIO_ADDR + 32'd2, 32'hFFFF_FFFF, 4'd3);
    add_req(1'b0, soc_pkg::SIZE_W, 32'h0000_0100, 32'h0, 4'd3);
    // random words back to back, then read back in the same order
    for (int n = 0; n < 32; n++) begin
      take_bits(10, a);
      take_bits(32, d);
      rnd_idx[n] = a[9:0];
      add_req(1'b1, soc_pkg::SIZE_W, {20'd0, a[9:0], 2'b00}, d, 4'd4);
    end
    for (int n = 0; n < 32; n++) begin
      add_req(1'b0, soc_pkg::SIZE_W, {20'd0, rnd_idx[n], 2'b00}, 32'h0, 4'd4);
    end
    // gpio masked writes, counter steps, counter ignores stores
    add_req(1'b0, soc_pkg::SIZE_W, GPIO_ADDR, 32'h0, 4'd5);
    add_req(1'b1, soc_pkg::SIZE_B, GPIO_ADDR + 32'd1, 32'h0000_005A, 4'd5);
    add_req(1'b0, soc_pkg::SIZE_W, GPIO_ADDR, 32'h0, 4'd5);
    add_req(1'b1, soc_pkg::SIZE_H, GPIO_ADDR + 32'd2, 32'h0000_BEEF, 4'd5);
    add_req(1'b0, soc_pkg::SIZE_W, GPIO_ADDR, 32'h0, 4'd5);
    add_req(1'b0, soc_pkg::SIZE_BU, GPIO_ADDR + 32'd3, 32'h0, 4'd5);
    add_req(1'b0, soc_pkg::SIZE_B, GPIO_ADDR + 32'd3, 32'h0, 4'd5);
    add_req(1'b0, soc_pkg::SIZE_HU, GPIO_ADDR + 32'd2, 32'h0, 4'd5);
    add_req(1'b1, soc_pkg::SIZE_W, GPIO_ADDR, 32'h0123_4567, 4'd5);
    add_req(1'b0, soc_pkg::SIZE_W, CNT_ADDR, 32'h0, 4'd5);  // first read only records
    add_req(1'b0, soc_pkg::SIZE_W, GPIO_ADDR, 32'h0, 4'd5);
    add_req(1'b0, soc_pkg::SIZE_W, GPIO_ADDR, 32'h0, 4'd5);
    add_req(1'b0, soc_pkg::SIZE_W, CNT_ADDR, 32'h0, 4'd5);  // 3 cycles later
    add_req(1'b0, soc_pkg::SIZE_W, CNT_ADDR, 32'h0, 4'd5);
    add_req(1'b1, soc_pkg::SIZE_W, CNT_ADDR, 32'hFFFF_FFFF, 4'd5);
    add_req(1'b0, soc_pkg::SIZE_W, CNT_ADDR, 32'h0, 4'd5);
    add_req(1'b0, soc_pkg::SIZE_W, GPIO_ADDR, 32'h0, 4'd5);
  endtask

  task automatic count_error(input int g);
    errs[g]++;
  endtask

  task automatic check_quiet(input logic [31:0] exp_gpio, input int g);
    checks[g] += 3;
    assert (resp.ready == 1'b0) else begin
      $display("error: resp.ready got 0x%h expected 0x0 while idle", resp.ready);
      count_error(g);
    end
    assert (resp.fault == 1'b0) else begin
      $display("error: resp.fault got 0x%h expected 0x0 while idle", resp.fault);
      count_error(g);
    end
    assert (gpio == exp_gpio) else begin
      $display("error: gpio got 0x%h expected 0x%h while idle", gpio, exp_gpio);
      count_error(g);
    end
  endtask

  task automatic check_resp(input int i);
    entry_t e;
    int     g;
    e = tbl[i];
    g = int'(e.grp);
    checks[g] += 3;
    assert (resp.ready == !e.exp_fault) else begin
      $display("error: resp.ready row %0d got 0x%h expected 0x%h", i, resp.ready, !e.exp_fault);
      count_error(g);
    end
    assert (resp.fault == e.exp_fault) else begin
      $display("error: resp.fault row %0d got 0x%h expected 0x%h", i, resp.fault, e.exp_fault);
      count_error(g);
    end
    assert (gpio == e.exp_gpio) else begin
      $display("error: gpio row %0d got 0x%h expected 0x%h", i, gpio, e.exp_gpio);
      count_error(g);
    end
    if (e.chk == CHK_DATA) begin
      checks[g]++;
      assert (resp.rdata == e.exp_data) else begin
        $display("error: resp.rdata row %0d got 0x%h expected 0x%h", i, resp.rdata, e.exp_data);
        count_error(g);
      end
    end else if (e.chk == CHK_DELTA) begin
      if (cnt_seen) begin
        checks[g]++;
        assert (resp.rdata - last_cnt == 32'(i - last_idx)) else begin
          $display("error: counter step row %0d got 0x%h expected 0x%h", i,
                   resp.rdata - last_cnt, 32'(i - last_idx));
          count_error(g);
        end
      end
      last_cnt = resp.rdata;
      last_idx = i;
      cnt_seen = 1'b1;
    end
    if (i == tbl.size() - 1 || tbl[i + 1].grp != e.grp) begin  // last row of this test
      $display("test %s: %0d checks, %0d errors", grp_name[g], checks[g], errs[g]);
    end
  endtask

  // watchdog sized from the table once it exists
  initial begin
    wait (table_built);
    #((tbl.size() + RST_CYCLES + QUIET_CYCLES + MARGIN_CYCLES) * PERIOD);
    $display("timeout: responses did not finish in time");
    $display("Testbench failed");
    $finish;
  end

  initial begin
    rst = 1'b1;
    req = '0;
    for (int g = 0; g < 7; g++) begin
      checks[g] = 0;
      errs[g]   = 0;
    end
    build_table();
    table_built = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    repeat (QUIET_CYCLES) begin
      @(negedge clk);
      check_quiet(32'd0, 0);  // nothing issued yet
    end
    $display("test %s: %0d checks, %0d errors", grp_name[0], checks[0], errs[0]);
    // row i is driven at edge i, its response checked half a cycle after edge i+1
    for (int i = 0; i <= tbl.size() + 1; i++) begin
      @(posedge clk);
      if (i < tbl.size()) begin
        req <= tbl[i].req;
      end else begin
        req <= '0;
      end
      @(negedge clk);
      if (i > 0 && i <= tbl.size()) begin
        check_resp(i - 1);
      end else if (i == tbl.size() + 1) begin
        check_quiet(gpio_model, 6);  // no extra pulse after the last row
        $display("test %s: %0d checks, %0d errors", grp_name[6], checks[6], errs[6]);
      end
    end
    total_checks = 0;
    total_errors = 0;
    for (int g = 0; g < 7; g++) begin
      total_checks += checks[g];
      total_errors += errs[g];
    end
    $display("summary: %0d checks, %0d errors", total_checks, total_errors);
    if (total_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: flist.f
source/soc_pkg.sv
source/store_align.sv
source/byte_lane_ram.sv
source/io_regs.sv
source/mem_decoder.sv
source/load_align.sv
source/mem_subsystem.sv
bench/mem_subsystem_tb.sv

// File: Makefile
# Verilator build and run of the data-memory subsystem testbench

VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = mem_subsystem_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: simulate clean

# build, run, then fail if the log holds the fail message
simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Testbench failed" $(LOG); then \
	  echo "simulation reported failure"; exit 1; \
	fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
